// File: hw/mem_port_pkg.sv
`default_nettype none

package mem_port_pkg;

    //////////////////////////////////////////////////
    // port geometry

    localparam int unsigned MEM_W  = 64;             // shared memory port width
    localparam int unsigned WORD_W = 32;             // requester word width
    localparam int unsigned LANES  = MEM_W / WORD_W; // 32-bit lanes per memory word
    localparam int unsigned LANE_W = 1;              // lane index width, picked by addr bit 2
    localparam int unsigned ADDR_W = 32;

    //////////////////////////////////////////////////
    // tracking queue

    // max number of requests in flight
    localparam int unsigned QUEUE_DEPTH = 32;
    localparam int unsigned CNT_W       = 6;                    // holds 0..QUEUE_DEPTH
    localparam int unsigned PTR_W       = $clog2(QUEUE_DEPTH);  // circular buffer index

    // owner of an outstanding request
    // vector reads and writes are split so that write answers can be dropped
    typedef enum logic [1:0] {
        SRC_INSTR     = 2'd0, // instruction fetch
        SRC_SCALAR    = 2'd1, // scalar load or store
        SRC_VEC_READ  = 2'd2, // vector load
        SRC_VEC_WRITE = 2'd3  // vector store, no answer expected
    } req_src_e;

endpackage

`default_nettype wire

// File: hw/mem_req_arbiter.sv
`default_nettype none

module mem_req_arbiter (
    // instruction fetch
    input  logic                                instr_req_i,
    input  logic [mem_port_pkg::ADDR_W-1:0]     instr_addr_i,
    output logic                                instr_gnt_o,

    // scalar data
    input  logic                                data_req_i,
    input  logic [mem_port_pkg::ADDR_W-1:0]     data_addr_i,
    input  logic                                data_we_i,
    input  logic [mem_port_pkg::WORD_W/8-1:0]   data_be_i,
    input  logic [mem_port_pkg::WORD_W-1:0]     data_wdata_i,
    output logic                                data_gnt_o,

    // vector data
    input  logic                                vec_req_i,
    input  logic [mem_port_pkg::ADDR_W-1:0]     vec_addr_i,
    input  logic                                vec_we_i,
    input  logic [mem_port_pkg::WORD_W/8-1:0]   vec_be_i,
    input  logic [mem_port_pkg::WORD_W-1:0]     vec_wdata_i,
    output logic                                vec_gnt_o,

    // shared memory request
    output logic                                mem_req_o,
    output logic [mem_port_pkg::ADDR_W-1:0]     mem_addr_o,
    output logic                                mem_we_o,
    output logic [mem_port_pkg::MEM_W/8-1:0]    mem_be_o,
    output logic [mem_port_pkg::MEM_W-1:0]      mem_wdata_o,

    req_tag_if.arb                              tag_o
);
    import mem_port_pkg::*;

    logic                vec_win;   // fixed priority: vector > scalar > fetch
    logic                data_win;
    logic                instr_win;
    logic [WORD_W/8-1:0] win_be;    // winner byte enables, word sized
    logic [WORD_W-1:0]   win_wdata;
    logic [LANE_W-1:0]   win_lane;
    req_src_e            win_src;

    // place word byte enables into the given lane of the wide word
    function automatic logic [MEM_W/8-1:0] lane_be(
        input logic [WORD_W/8-1:0] be,
        input logic [LANE_W-1:0]   lane
    );
        logic [MEM_W/8-1:0] res;
        res = '0;
        res[lane*(WORD_W/8) +: WORD_W/8] = be;
        return res;
    endfunction

    //////////////////////////////////////////////////
    // winner select

    assign vec_win   = vec_req_i;
    assign data_win  = data_req_i & ~vec_req_i;
    assign instr_win = instr_req_i & ~data_req_i & ~vec_req_i;

    // full queue holds off every grant
    assign vec_gnt_o   = vec_win   & ~tag_o.full;
    assign data_gnt_o  = data_win  & ~tag_o.full;
    assign instr_gnt_o = instr_win & ~tag_o.full;
    assign mem_req_o   = (vec_win | data_win | instr_win) & ~tag_o.full;

    always_comb begin
        // fetch by default, read only
        mem_addr_o = instr_addr_i;
        mem_we_o   = 1'b0;
        win_be     = '0;
        win_wdata  = '0;
        win_src    = SRC_INSTR;
        if (vec_win) begin
            mem_addr_o = vec_addr_i;
            mem_we_o   = vec_we_i;
            win_be     = vec_be_i;
            win_wdata  = vec_wdata_i;
            win_src    = vec_we_i ? SRC_VEC_WRITE : SRC_VEC_READ; // writes get no answer
        end else if (data_win) begin
            mem_addr_o = data_addr_i;
            mem_we_o   = data_we_i;
            win_be     = data_be_i;
            win_wdata  = data_wdata_i;
            win_src    = SRC_SCALAR;
        end
    end

    //////////////////////////////////////////////////
    // lane alignment

    assign win_lane = mem_addr_o[2 +: LANE_W]; // addr bit 2 picks the 32-bit lane

    // fetch reads the whole wide word
    assign mem_be_o    = instr_win ? '1 : lane_be(win_be, win_lane);
    assign mem_wdata_o = {LANES{win_wdata}}; // same word in every lane

    // tag for the tracking queue
    assign tag_o.push = mem_req_o;
    assign tag_o.src  = win_src;
    assign tag_o.lane = win_lane;

endmodule

`default_nettype wire

// File: hw/req_tag_if.sv
`default_nettype none

// tag of a freshly granted request, arbiter -> tracking queue
interface req_tag_if;
    import mem_port_pkg::*;

    logic              push; // one grant this cycle
    req_src_e          src;  // who gets the answer
    logic [LANE_W-1:0] lane; // lane of the wide word used
    logic              full; // queue cannot take another tag

    // arbiter side, only pushes while full is low
    modport arb (
        output push,
        output src,
        output lane,
        input  full
    );

    modport queue (
        input  push,
        input  src,
        input  lane,
        output full
    );

endinterface

`default_nettype wire

// File: hw/req_tag_queue.sv
`default_nettype none

module req_tag_queue (
    input  logic       clk_i,
    input  logic       rst_ni,

    req_tag_if.queue   tag_i,  // push side from the arbiter
    resp_tag_if.queue  head_o  // pop side toward the router
);
    import mem_port_pkg::*;

    req_src_e          src_mem  [QUEUE_DEPTH]; // owner per entry
    logic [LANE_W-1:0] lane_mem [QUEUE_DEPTH]; // lane per entry
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;                  // entries in use up to QUEUE_DEPTH
    logic              do_push;
    logic              do_pop;

    //////////////////////////////////////////////////
    // status

    assign tag_i.full   = (count == CNT_W'(QUEUE_DEPTH));
    assign head_o.valid = (count != '0);

    assign do_push = tag_i.push;                  // one tag per grant
    assign do_pop  = head_o.pop & head_o.valid;

    //////////////////////////////////////////////////
    // storage

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            src_mem[wr_ptr]  <= tag_i.src;
            lane_mem[wr_ptr] <= tag_i.lane;
        end
    end

    // pointers wrap since the depth is a power of two
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count; // both or neither leaves the count
            endcase
        end
    end

    // head is the oldest outstanding request
    assign head_o.src  = src_mem[rd_ptr];
    assign head_o.lane = lane_mem[rd_ptr];

endmodule

`default_nettype wire

// File: hw/resp_router.sv
`default_nettype none

module resp_router (
    // memory response
    input  logic                                mem_rvalid_i,
    input  logic                                mem_err_i,
    input  logic [mem_port_pkg::MEM_W-1:0]      mem_rdata_i,

    resp_tag_if.router                          head_i, // owner of this answer

    // per requester responses
    output logic                                instr_rvalid_o,
    output logic [mem_port_pkg::WORD_W-1:0]     instr_rdata_o,
    output logic                                instr_err_o,
    output logic                                data_rvalid_o,
    output logic [mem_port_pkg::WORD_W-1:0]     data_rdata_o,
    output logic                                data_err_o,
    output logic                                vec_rvalid_o,
    output logic [mem_port_pkg::WORD_W-1:0]     vec_rdata_o,
    output logic                                vec_err_o
);
    import mem_port_pkg::*;

    logic              resp_ok;   // answer with a tag behind it
    logic [WORD_W-1:0] lane_word; // addressed lane of the read data

    // every answer retires the head tag
    assign head_i.pop = mem_rvalid_i;
    assign resp_ok    = mem_rvalid_i & head_i.valid;

    assign lane_word = mem_rdata_i[head_i.lane*WORD_W +: WORD_W];

    //////////////////////////////////////////////////
    // owner decode

    always_comb begin
        instr_rvalid_o = 1'b0;
        data_rvalid_o  = 1'b0;
        vec_rvalid_o   = 1'b0;
        case (head_i.src)
            SRC_INSTR:    instr_rvalid_o = resp_ok;
            SRC_SCALAR:   data_rvalid_o  = resp_ok;
            SRC_VEC_READ: vec_rvalid_o   = resp_ok;
            // vector unit only waits for load answers, store answer swallowed
            default:      vec_rvalid_o   = 1'b0;
        endcase
    end

    // error bit only to the owner
    assign instr_err_o = instr_rvalid_o & mem_err_i;
    assign data_err_o  = data_rvalid_o  & mem_err_i;
    assign vec_err_o   = vec_rvalid_o   & mem_err_i;

    // same lane word to all, only the owner sees rvalid
    assign instr_rdata_o = lane_word;
    assign data_rdata_o  = lane_word;
    assign vec_rdata_o   = lane_word;

endmodule

`default_nettype wire

// File: hw/resp_tag_if.sv
`default_nettype none

// oldest outstanding tag, tracking queue -> response router
interface resp_tag_if;
    import mem_port_pkg::*;

    logic              valid; // queue not empty
    req_src_e          src;   // owner of the next answer
    logic [LANE_W-1:0] lane;  // lane to pull out of the read data
    logic              pop;   // answer consumed, follows mem_rvalid_i

    modport queue (
        output valid,
        output src,
        output lane,
        input  pop
    );

    modport router (
        input  valid,
        input  src,
        input  lane,
        output pop
    );

endinterface

`default_nettype wire

// File: hw/shared_mem_port.sv
`default_nettype none

module shared_mem_port (
    input  logic                                clk_i,
    input  logic                                rst_ni,

    // instruction fetch
    input  logic                                instr_req_i,
    input  logic [mem_port_pkg::ADDR_W-1:0]     instr_addr_i,
    output logic                                instr_gnt_o,
    output logic                                instr_rvalid_o,
    output logic [mem_port_pkg::WORD_W-1:0]     instr_rdata_o,
    output logic                                instr_err_o,

    // scalar data
    input  logic                                data_req_i,
    input  logic [mem_port_pkg::ADDR_W-1:0]     data_addr_i,
    input  logic                                data_we_i,
    input  logic [mem_port_pkg::WORD_W/8-1:0]   data_be_i,
    input  logic [mem_port_pkg::WORD_W-1:0]     data_wdata_i,
    output logic                                data_gnt_o,
    output logic                                data_rvalid_o,
    output logic [mem_port_pkg::WORD_W-1:0]     data_rdata_o,
    output logic                                data_err_o,

    // vector data
    input  logic                                vec_req_i,
    input  logic [mem_port_pkg::ADDR_W-1:0]     vec_addr_i,
    input  logic                                vec_we_i,
    input  logic [mem_port_pkg::WORD_W/8-1:0]   vec_be_i,
    input  logic [mem_port_pkg::WORD_W-1:0]     vec_wdata_i,
    output logic                                vec_gnt_o,
    output logic                                vec_rvalid_o,
    output logic [mem_port_pkg::WORD_W-1:0]     vec_rdata_o,
    output logic                                vec_err_o,

    // shared memory port
    output logic                                mem_req_o,
    output logic [mem_port_pkg::ADDR_W-1:0]     mem_addr_o,
    output logic                                mem_we_o,
    output logic [mem_port_pkg::MEM_W/8-1:0]    mem_be_o,
    output logic [mem_port_pkg::MEM_W-1:0]      mem_wdata_o,
    input  logic                                mem_rvalid_i,
    input  logic                                mem_err_i,
    input  logic [mem_port_pkg::MEM_W-1:0]      mem_rdata_i
);

    req_tag_if  req_tag ();  // grant -> queue
    resp_tag_if resp_tag (); // queue head -> router

    //////////////////////////////////////////////////
    // request path

    mem_req_arbiter arb_i (
        .instr_req_i  (instr_req_i),
        .instr_addr_i (instr_addr_i),
        .instr_gnt_o  (instr_gnt_o),
        .data_req_i   (data_req_i),
        .data_addr_i  (data_addr_i),
        .data_we_i    (data_we_i),
        .data_be_i    (data_be_i),
        .data_wdata_i (data_wdata_i),
        .data_gnt_o   (data_gnt_o),
        .vec_req_i    (vec_req_i),
        .vec_addr_i   (vec_addr_i),
        .vec_we_i     (vec_we_i),
        .vec_be_i     (vec_be_i),
        .vec_wdata_i  (vec_wdata_i),
        .vec_gnt_o    (vec_gnt_o),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_we_o     (mem_we_o),
        .mem_be_o     (mem_be_o),
        .mem_wdata_o  (mem_wdata_o),
        .tag_o        (req_tag.arb)
    );

    // in-order tags of outstanding requests
    req_tag_queue queue_i (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .tag_i  (req_tag.queue),
        .head_o (resp_tag.queue)
    );

    //////////////////////////////////////////////////
    // response path

    resp_router router_i (
        .mem_rvalid_i   (mem_rvalid_i),
        .mem_err_i      (mem_err_i),
        .mem_rdata_i    (mem_rdata_i),
        .head_i         (resp_tag.router),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .instr_err_o    (instr_err_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .data_err_o     (data_err_o),
        .vec_rvalid_o   (vec_rvalid_o),
        .vec_rdata_o    (vec_rdata_o),
        .vec_err_o      (vec_err_o)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the shared memory port testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module tb_shared_mem_port --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit $status
fi
exit 0

// File: sim.f
+incdir+test
hw/mem_port_pkg.sv
hw/req_tag_if.sv
hw/resp_tag_if.sv
hw/mem_req_arbiter.sv
hw/req_tag_queue.sv
hw/resp_router.sv
hw/shared_mem_port.sv
test/tb_shared_mem_port.sv

// File: test/mem_model.svh
`ifndef MEM_MODEL_SVH
`define MEM_MODEL_SVH

//////////////////////////////////////////////////
// memory model and answer scheduler

localparam int MEM_WORDS = 16; // wide words, picked by addr bits 6:3

typedef struct packed {
    req_src_e          src;  // owner of the answer
    logic [LANE_W-1:0] lane;
    logic [MEM_W-1:0]  data; // wide word as seen at grant time
} exp_resp_t;

logic [MEM_W-1:0] mem_words [MEM_WORDS];
exp_resp_t        exp_q [$];  // expected answers, grant order
logic [31:0]      rng_state;
logic             hold_off;   // memory keeps quiet while set
int               resp_wait;  // idle cycles before the next answer

// xorshift32
function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// 16 wide words, both lanes
function automatic logic [ADDR_W-1:0] rand_addr();
    logic [31:0] r;
    r = next_rand();
    return {25'd0, r[6:2], 2'b00};
endfunction

task automatic init_model();
    rng_state = 32'h428b_2dff;
    hold_off  = 1'b0;
    resp_wait = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
        mem_words[i] = {32'(i) * 32'h9e37_79b9 ^ 32'hc0de_0000, ~(32'(i) * 32'h0101_0101)};
    end
endtask

// byte-wise store under the wide byte enables
task automatic write_model(input logic [ADDR_W-1:0] addr, input logic [MEM_W/8-1:0] be,
                           input logic [MEM_W-1:0] wdata);
    for (int b = 0; b < MEM_W/8; b++) begin
        if (be[b]) begin
            mem_words[addr[6:3]][b*8 +: 8] = wdata[b*8 +: 8];
        end
    end
endtask

// answer for the next cycle, oldest entry only
task automatic plan_resp(output logic vld, output logic err, output logic [MEM_W-1:0] data);
    logic [31:0] r;
    vld  = 1'b0;
    err  = 1'b0;
    data = '0;
    if (!hold_off && exp_q.size() != 0) begin
        if (resp_wait == 0) begin
            r         = next_rand();
            vld       = 1'b1;
            err       = (r[3:0] == 4'd0); // rare bus error
            data      = exp_q[0].data;
            resp_wait = int'(r[9:8]);     // gap to the following answer
        end else begin
            resp_wait = resp_wait - 1;
        end
    end
endtask

`endif

// File: test/tb_shared_mem_port.sv
`default_nettype none

module tb_shared_mem_port;
    import mem_port_pkg::*;

    localparam int unsigned N_TXN      = 400; // grants in the run
    localparam int unsigned HOLD_AT    = 150; // grant count that starts hold-off
    localparam int unsigned CLK_PERIOD = 4;

    logic                clk_i = 1'b0;
    logic                rst_ni;
    logic                instr_req_i, data_req_i, data_we_i, vec_req_i, vec_we_i;
    logic [ADDR_W-1:0]   instr_addr_i, data_addr_i, vec_addr_i;
    logic [WORD_W/8-1:0] data_be_i, vec_be_i;
    logic [WORD_W-1:0]   data_wdata_i, vec_wdata_i;
    logic                mem_rvalid_i, mem_err_i;
    logic [MEM_W-1:0]    mem_rdata_i;
    logic                instr_gnt_o, instr_rvalid_o, instr_err_o;
    logic                data_gnt_o, data_rvalid_o, data_err_o;
    logic                vec_gnt_o, vec_rvalid_o, vec_err_o;
    logic [WORD_W-1:0]   instr_rdata_o, data_rdata_o, vec_rdata_o;
    logic                mem_req_o, mem_we_o;
    logic [ADDR_W-1:0]   mem_addr_o;
    logic [MEM_W/8-1:0]  mem_be_o;
    logic [MEM_W-1:0]    mem_wdata_o;

    int unsigned      grants;    // requests granted so far
    int unsigned      hold_cnt;  // full cycles seen during hold-off
    logic             gnt_instr, gnt_data, gnt_vec; // expected winner this cycle
    logic             nx_vld, nx_err;
    logic [MEM_W-1:0] nx_data;
    logic             done;

    `include "mem_model.svh"

    shared_mem_port dut_i (.*);

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    initial begin
        #(20 * N_TXN * CLK_PERIOD); // watchdog
        $display(">>> FAIL");
        $display("timeout, the run did not finish in time");
        $fatal(1);
    end

    task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] want);
        assert (got === want) else begin
            $display(">>> FAIL");
            $display("Error: %s = 0x%h, expected 0x%h", name, got, want);
            $fatal(1);
        end
    endtask

    //////////////////////////////////////////////////
    // per cycle scoreboard, sampled at the falling edge

    task automatic score_cycle();
        logic               full_exp;
        logic [ADDR_W-1:0]  addr;
        logic               we;
        logic [3:0]         be;
        logic [31:0]        word;
        logic [MEM_W/8-1:0] be_exp;
        exp_resp_t          ent;
        full_exp = (exp_q.size() == QUEUE_DEPTH); // queue count before this edge
        if (mem_rvalid_i) begin
            ent  = exp_q.pop_front();                          // in order, oldest first
            word = ent.lane ? ent.data[63:32] : ent.data[31:0];
            expect_eq("instr_rvalid_o", 64'(instr_rvalid_o), 64'(ent.src == SRC_INSTR));
            expect_eq("data_rvalid_o", 64'(data_rvalid_o), 64'(ent.src == SRC_SCALAR));
            expect_eq("vec_rvalid_o", 64'(vec_rvalid_o), 64'(ent.src == SRC_VEC_READ));
            expect_eq("instr_err_o", 64'(instr_err_o), 64'(ent.src == SRC_INSTR && mem_err_i));
            expect_eq("data_err_o", 64'(data_err_o), 64'(ent.src == SRC_SCALAR && mem_err_i));
            expect_eq("vec_err_o", 64'(vec_err_o), 64'(ent.src == SRC_VEC_READ && mem_err_i));
            if (ent.src == SRC_INSTR) expect_eq("instr_rdata_o", 64'(instr_rdata_o), 64'(word));
            if (ent.src == SRC_SCALAR) expect_eq("data_rdata_o", 64'(data_rdata_o), 64'(word));
            if (ent.src == SRC_VEC_READ) expect_eq("vec_rdata_o", 64'(vec_rdata_o), 64'(word));
        end else begin
            expect_eq("rvalid_o {instr,data,vec}",
                      64'({instr_rvalid_o, data_rvalid_o, vec_rvalid_o}), 64'(0));
        end
        // fixed priority, vector first, nothing while full
        gnt_vec   = vec_req_i & ~full_exp;
        gnt_data  = data_req_i & ~vec_req_i & ~full_exp;
        gnt_instr = instr_req_i & ~data_req_i & ~vec_req_i & ~full_exp;
        expect_eq("vec_gnt_o", 64'(vec_gnt_o), 64'(gnt_vec));
        expect_eq("data_gnt_o", 64'(data_gnt_o), 64'(gnt_data));
        expect_eq("instr_gnt_o", 64'(instr_gnt_o), 64'(gnt_instr));
        expect_eq("mem_req_o", 64'(mem_req_o), 64'(gnt_vec | gnt_data | gnt_instr));
        if (gnt_vec | gnt_data | gnt_instr) begin
            addr    = instr_addr_i;
            we      = 1'b0;
            be      = '0;
            word    = '0;
            ent.src = SRC_INSTR;
            if (gnt_vec) begin
                addr    = vec_addr_i;
                we      = vec_we_i;
                be      = vec_be_i;
                word    = vec_wdata_i;
                ent.src = vec_we_i ? SRC_VEC_WRITE : SRC_VEC_READ;
            end else if (gnt_data) begin
                addr    = data_addr_i;
                we      = data_we_i;
                be      = data_be_i;
                word    = data_wdata_i;
                ent.src = SRC_SCALAR;
            end
            be_exp = addr[2] ? {be, 4'h0} : {4'h0, be}; // lane from addr bit 2
            expect_eq("mem_addr_o", 64'(mem_addr_o), 64'(addr));
            expect_eq("mem_we_o", 64'(mem_we_o), 64'(we));
            if (gnt_instr) expect_eq("mem_be_o", 64'(mem_be_o), 64'hff);
            if (we) begin
                expect_eq("mem_be_o", 64'(mem_be_o), 64'(be_exp));
                expect_eq("mem_wdata_o", mem_wdata_o, {word, word});
                write_model(addr, be_exp, {word, word});
            end
            ent.lane = addr[2];
            ent.data = mem_words[addr[6:3]];
            exp_q.push_back(ent);
            grants++;
        end
        // hold-off: fill the queue once, then let it drain
        if (hold_off && full_exp) hold_cnt++;
        if (hold_cnt >= 6) hold_off = 1'b0;
        else if (grants >= HOLD_AT) hold_off = 1'b1;
    endtask

    // new request once the old one is granted, held otherwise
    task automatic drive_inputs();
        logic [31:0] r;
        r = next_rand();
        mem_rvalid_i <= nx_vld;
        mem_err_i    <= nx_err;
        mem_rdata_i  <= nx_data;
        if (gnt_instr || !instr_req_i) begin
            instr_req_i  <= hold_off || (grants < N_TXN && r[0]);
            instr_addr_i <= rand_addr();
        end
        if (gnt_data || !data_req_i) begin
            data_req_i   <= hold_off || (grants < N_TXN && r[1]);
            data_addr_i  <= rand_addr();
            data_we_i    <= r[2];
            data_be_i    <= r[7:4];
            data_wdata_i <= next_rand();
        end
        if (gnt_vec || !vec_req_i) begin
            vec_req_i   <= hold_off || (grants < N_TXN && r[8] && r[9]); // lighter load
            vec_addr_i  <= rand_addr();
            vec_we_i    <= r[10];
            vec_be_i    <= r[15:12];
            vec_wdata_i <= next_rand();
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence

    initial begin
        init_model();
        {rst_ni, instr_req_i, data_req_i, data_we_i, vec_req_i, vec_we_i} = '0;
        {instr_addr_i, data_addr_i, vec_addr_i} = '0;
        {data_be_i, vec_be_i, data_wdata_i, vec_wdata_i} = '0;
        {mem_rvalid_i, mem_err_i, mem_rdata_i} = '0;
        {gnt_instr, gnt_data, gnt_vec, nx_vld, nx_err, nx_data} = '0;
        grants   = 0;
        hold_cnt = 0;
        done     = 1'b0;
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        while (!done) begin
            @(negedge clk_i);
            score_cycle();
            plan_resp(nx_vld, nx_err, nx_data);
            done = (grants >= N_TXN) && (exp_q.size() == 0); // empty queue, nothing waiting
            if (!done) begin
                @(posedge clk_i);
                drive_inputs();
            end
        end
        if (hold_cnt < 6) begin
            $display(">>> FAIL");
            $display("the tag queue never stayed full, back-pressure was not exercised");
            $fatal(1);
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
